/* src/rvv_uop_pkg.sv */
/*
 Micro-op constants shared by the dispatch blocks.
 The slot count is fixed at two and the logic assumes it.
*/
`default_nettype none

package rvv_uop_pkg;

    // Uops looked at per cycle
    localparam int NUM_DP_UOP = 2;

    // Vector register index width
    localparam int REG_IDX_W = 5;

    // Vector sources per uop (vs1, vs2, vs3), vs3 is read at vd
    localparam int NUM_SRC = 3;

    // Execution unit codes
    localparam logic EXE_ALU = 1'b0;
    localparam logic EXE_MUL = 1'b1;

endpackage

`default_nettype wire

/* src/rvv_res_pkg.sv */
/*
 Back-end resource constants.
 ROB depth must stay a power of two.
*/
`default_nettype none

package rvv_res_pkg;

    // VRF read ports available to dispatch
    localparam int NUM_VRF_RD = 4;

    // Defaults for the top level
    localparam int DEF_ROB_DEPTH = 8;
    localparam int DEF_VLEN = 128;

    // ROB write target, held in rob_xrf
    localparam logic W_VRF = 1'b0;
    localparam logic W_XRF = 1'b1;

endpackage

`default_nettype wire

/* src/dispatch_vrf_read.sv */
/*
 VRF read port packing for both slots.
 Slot 1 gets ports only when the total source count fits the port budget.
*/
`default_nettype none

module dispatch_vrf_read #(
    parameter int VLEN = rvv_res_pkg::DEF_VLEN,
    localparam int NS = rvv_uop_pkg::NUM_DP_UOP,
    localparam int RW = rvv_uop_pkg::REG_IDX_W,
    localparam int NSRC = rvv_uop_pkg::NUM_SRC,
    localparam int NRD = rvv_res_pkg::NUM_VRF_RD,
    localparam int PW = $clog2(NRD),
    localparam int CW = $clog2(NS * NSRC + 1),
    localparam int OW = $clog2(NS * NSRC)
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [NS-1:0][RW-1:0]           vs1_index,
    input  logic [NS-1:0]                   vs1_valid,
    input  logic [NS-1:0][RW-1:0]           vs2_index,
    input  logic [NS-1:0]                   vs2_valid,
    input  logic [NS-1:0][RW-1:0]           vd_index,
    input  logic [NS-1:0]                   vs3_valid,
    input  logic [NRD-1:0][VLEN-1:0]        vrf_rd_data,
    output logic [NRD-1:0][RW-1:0]          vrf_rd_index,
    output logic                            strct_hazard,
    output logic [NS-1:0][NSRC-1:0][VLEN-1:0] src_vrf_data
);

    logic [NS-1:0][NSRC-1:0][RW-1:0] src_index;
    logic [NS-1:0][NSRC-1:0]         src_valid;
    logic [NS-1:0][NSRC-1:0][PW-1:0] src_port;
    logic [NS-1:0][NSRC-1:0]         src_hit;
    logic [NRD-1:0]                  port_used;
    logic [NRD-1:0][OW-1:0]          port_owner;
    logic [CW-1:0]                   src_total;

    for (genvar s = 0; s < NS; s++) begin : g_src
        assign src_index[s] = {vd_index[s], vs2_index[s], vs1_index[s]};
        assign src_valid[s] = {vs3_valid[s], vs2_valid[s], vs1_valid[s]};
    end

    always_comb begin
        src_total = '0;
        for (int s = 0; s < NS; s++) begin
            for (int k = 0; k < NSRC; k++) begin
                src_total = src_total + CW'(src_valid[s][k]);
            end
        end
    end

    assign strct_hazard = src_total > CW'(NRD);

    // Hand out ports in slot order, vs1 then vs2 then vs3
    always_comb begin
        int p;
        p = 0;
        vrf_rd_index = '0;
        port_used = '0;
        port_owner = '0;
        src_port = '0;
        src_hit = '0;
        for (int s = 0; s < NS; s++) begin
            for (int k = 0; k < NSRC; k++) begin
                if (src_valid[s][k] && (s == 0 || !strct_hazard) && p < NRD) begin
                    vrf_rd_index[p] = src_index[s][k];
                    port_used[p] = 1'b1;
                    port_owner[p] = OW'(s * NSRC + k);
                    src_port[s][k] = PW'(p);
                    src_hit[s][k] = 1'b1;
                    p = p + 1;
                end
            end
        end
    end

    // Return path, unread sources see zero
    for (genvar s = 0; s < NS; s++) begin : g_ret
        for (genvar k = 0; k < NSRC; k++) begin : g_src_ret
            assign src_vrf_data[s][k] = src_hit[s][k] ? vrf_rd_data[src_port[s][k]] : '0;
        end
    end

    for (genvar a = 0; a < NRD; a++) begin : g_own_a
        for (genvar b = a + 1; b < NRD; b++) begin : g_own_b
            a_port_owner: assert property (@(posedge clk) disable iff (!rst_n)
                port_used[a] && port_used[b] |-> port_owner[a] != port_owner[b]);
        end
    end

endmodule

`default_nettype wire

/* src/dispatch_rob_forward.sv */
/*
 ROB RAW search and operand select for one slot.
 Entries are scanned from rob_head, so ROB_DEPTH must be a power of two.
*/
`default_nettype none

module dispatch_rob_forward #(
    parameter int ROB_DEPTH = rvv_res_pkg::DEF_ROB_DEPTH,
    parameter int VLEN = rvv_res_pkg::DEF_VLEN,
    localparam int RW = rvv_uop_pkg::REG_IDX_W,
    localparam int NSRC = rvv_uop_pkg::NUM_SRC,
    localparam int ROB_AW = $clog2(ROB_DEPTH)
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [RW-1:0]                  vs1_index,
    input  logic                           vs1_valid,
    input  logic [RW-1:0]                  vs2_index,
    input  logic                           vs2_valid,
    input  logic [RW-1:0]                  vd_index,
    input  logic                           vs3_valid,
    input  logic [NSRC-1:0][VLEN-1:0]      src_vrf_data,
    input  logic [ROB_DEPTH-1:0]           rob_valid,
    input  logic [ROB_DEPTH-1:0]           rob_done,
    input  logic [ROB_DEPTH-1:0]           rob_xrf,
    input  logic [ROB_DEPTH-1:0][RW-1:0]   rob_w_index,
    input  logic [ROB_DEPTH-1:0][VLEN-1:0] rob_w_data,
    input  logic [ROB_AW-1:0]              rob_head,
    output logic                           raw_rob,
    output logic [VLEN-1:0]                vs1_data,
    output logic [VLEN-1:0]                vs2_data,
    output logic [VLEN-1:0]                vs3_data
);

    logic [NSRC-1:0][RW-1:0]   src_index;
    logic [NSRC-1:0]           src_valid;
    logic [NSRC-1:0][VLEN-1:0] src_data;

    // vs3 reads the register named by vd
    assign src_index = {vd_index, vs2_index, vs1_index};
    assign src_valid = {vs3_valid, vs2_valid, vs1_valid};

    // Walk oldest to youngest so the last match wins
    always_comb begin
        logic [ROB_AW-1:0] ent;
        ent = '0;
        raw_rob = 1'b0;
        for (int s = 0; s < NSRC; s++) begin
            src_data[s] = src_vrf_data[s];
            for (int k = 0; k < ROB_DEPTH; k++) begin
                ent = rob_head + ROB_AW'(k);
                if (src_valid[s] && rob_valid[ent] &&
                    (rob_xrf[ent] == rvv_res_pkg::W_VRF) &&
                    (rob_w_index[ent] == src_index[s])) begin
                    src_data[s] = rob_w_data[ent];
                    // Any pending writer stalls the slot
                    if (!rob_done[ent]) begin
                        raw_rob = 1'b1;
                    end
                end
            end
        end
    end

    assign vs1_data = src_data[0];
    assign vs2_data = src_data[1];
    assign vs3_data = src_data[2];

    a_no_src_no_raw: assert property (@(posedge clk) disable iff (!rst_n)
        !(|src_valid) |-> !raw_rob);

endmodule

`default_nettype wire

/* src/dispatch_ctrl.sv */
/*
 In-order issue control for the two dispatch slots.
 Slot 1 never issues without slot 0, and takes the next ROB address.
*/
`default_nettype none

module dispatch_ctrl #(
    parameter int ROB_DEPTH = rvv_res_pkg::DEF_ROB_DEPTH,
    localparam int NS = rvv_uop_pkg::NUM_DP_UOP,
    localparam int RW = rvv_uop_pkg::REG_IDX_W,
    localparam int ROB_AW = $clog2(ROB_DEPTH)
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [NS-1:0]             uop_valid,
    input  logic [NS-1:0]             uop_exe,
    input  logic [NS-1:0][RW-1:0]     vd_index,
    input  logic [NS-1:0]             vd_valid,
    input  logic [NS-1:0][RW-1:0]     vs1_index,
    input  logic [NS-1:0]             vs1_valid,
    input  logic [NS-1:0][RW-1:0]     vs2_index,
    input  logic [NS-1:0]             vs2_valid,
    input  logic [NS-1:0]             vs3_valid,
    input  logic [NS-1:0]             raw_rob,
    input  logic                      strct_hazard,
    input  logic [ROB_AW-1:0]         rob_tail,
    input  logic [NS-1:0]             alu_ready,
    input  logic [NS-1:0]             mul_ready,
    input  logic [NS-1:0]             rob_ready,
    output logic [NS-1:0]             uop_ready,
    output logic [NS-1:0]             rob_push,
    output logic [NS-1:0][RW-1:0]     rob_push_vd,
    output logic [NS-1:0]             alu_valid,
    output logic [NS-1:0]             mul_valid,
    output logic [NS-1:0][ROB_AW-1:0] rs_rob_addr
);

    logic [NS-1:0] rs_ready;
    logic [NS-1:0] is_mul;
    logic          raw_uop;
    logic [NS-1:0] issue;

    for (genvar s = 0; s < NS; s++) begin : g_rs_sel
        assign is_mul[s] = uop_exe[s] == rvv_uop_pkg::EXE_MUL;
        assign rs_ready[s] = is_mul[s] ? mul_ready[s] : alu_ready[s];
    end

    // Slot 1 reading slot 0's destination
    assign raw_uop = vd_valid[0] &&
                     ((vs1_valid[1] && vs1_index[1] == vd_index[0]) ||
                      (vs2_valid[1] && vs2_index[1] == vd_index[0]) ||
                      (vs3_valid[1] && vd_index[1] == vd_index[0]));

    assign issue[0] = uop_valid[0] && !raw_rob[0] && rs_ready[0] && rob_ready[0];
    assign issue[1] = issue[0] && uop_valid[1] && !raw_rob[1] && !raw_uop &&
                      !strct_hazard && rs_ready[1] && rob_ready[1];

    for (genvar s = 0; s < NS; s++) begin : g_out
        assign uop_ready[s] = issue[s];
        assign rob_push[s] = issue[s];
        assign rob_push_vd[s] = vd_index[s];
        assign alu_valid[s] = issue[s] && !is_mul[s];
        assign mul_valid[s] = issue[s] && is_mul[s];
        // Wraps naturally at the power-of-two depth
        assign rs_rob_addr[s] = rob_tail + ROB_AW'(s);

        a_one_station: assert property (@(posedge clk) disable iff (!rst_n)
            !(alu_valid[s] && mul_valid[s]));
        a_push_on_issue: assert property (@(posedge clk) disable iff (!rst_n)
            uop_ready[s] |-> rob_push[s]);
    end

    a_in_order: assert property (@(posedge clk) disable iff (!rst_n)
        uop_ready[1] |-> uop_ready[0]);

endmodule

`default_nettype wire

/* src/rvv_dispatch.sv */
/*
 Two-wide vector dispatch, purely combinational.
 VRF data must come back in the same cycle as the read index.
 clk and rst_n only clock the assertions.
*/
`default_nettype none

module rvv_dispatch #(
    parameter int ROB_DEPTH = rvv_res_pkg::DEF_ROB_DEPTH,
    parameter int VLEN = rvv_res_pkg::DEF_VLEN,
    localparam int NS = rvv_uop_pkg::NUM_DP_UOP,
    localparam int RW = rvv_uop_pkg::REG_IDX_W,
    localparam int NRD = rvv_res_pkg::NUM_VRF_RD,
    localparam int ROB_AW = $clog2(ROB_DEPTH)
) (
    input  logic                             clk,
    input  logic                             rst_n,
    // Uop queue
    input  logic [NS-1:0]                    uop_valid,
    input  logic [NS-1:0]                    uop_exe,
    input  logic [NS-1:0][RW-1:0]            vs1_index,
    input  logic [NS-1:0]                    vs1_valid,
    input  logic [NS-1:0][RW-1:0]            vs2_index,
    input  logic [NS-1:0]                    vs2_valid,
    input  logic [NS-1:0][RW-1:0]            vd_index,
    input  logic [NS-1:0]                    vd_valid,
    input  logic [NS-1:0]                    vs3_valid,
    output logic [NS-1:0]                    uop_ready,
    // ROB entries
    input  logic [ROB_DEPTH-1:0]             rob_valid,
    input  logic [ROB_DEPTH-1:0]             rob_done,
    input  logic [ROB_DEPTH-1:0]             rob_xrf,
    input  logic [ROB_DEPTH-1:0][RW-1:0]     rob_w_index,
    input  logic [ROB_DEPTH-1:0][VLEN-1:0]   rob_w_data,
    input  logic [ROB_AW-1:0]                rob_head,
    input  logic [ROB_AW-1:0]                rob_tail,
    // ROB push
    output logic [NS-1:0]                    rob_push,
    output logic [NS-1:0][RW-1:0]            rob_push_vd,
    input  logic [NS-1:0]                    rob_ready,
    // Reservation stations
    output logic [NS-1:0]                    alu_valid,
    input  logic [NS-1:0]                    alu_ready,
    output logic [NS-1:0]                    mul_valid,
    input  logic [NS-1:0]                    mul_ready,
    output logic [NS-1:0][ROB_AW-1:0]        rs_rob_addr,
    output logic [NS-1:0][VLEN-1:0]          rs_vs1_data,
    output logic [NS-1:0][VLEN-1:0]          rs_vs2_data,
    output logic [NS-1:0][VLEN-1:0]          rs_vs3_data,
    // VRF read
    output logic [NRD-1:0][RW-1:0]           vrf_rd_index,
    input  logic [NRD-1:0][VLEN-1:0]         vrf_rd_data
);

    logic [NS-1:0][rvv_uop_pkg::NUM_SRC-1:0][VLEN-1:0] src_vrf_data;
    logic                                              strct_hazard;
    logic [NS-1:0]                                     raw_rob;

    dispatch_vrf_read #(.VLEN(VLEN)) u_vrf_read (
        .clk          (clk),
        .rst_n        (rst_n),
        .vs1_index    (vs1_index),
        .vs1_valid    (vs1_valid),
        .vs2_index    (vs2_index),
        .vs2_valid    (vs2_valid),
        .vd_index     (vd_index),
        .vs3_valid    (vs3_valid),
        .vrf_rd_data  (vrf_rd_data),
        .vrf_rd_index (vrf_rd_index),
        .strct_hazard (strct_hazard),
        .src_vrf_data (src_vrf_data)
    );

    for (genvar s = 0; s < NS; s++) begin : g_fwd
        dispatch_rob_forward #(.ROB_DEPTH(ROB_DEPTH), .VLEN(VLEN)) u_rob_forward (
            .clk          (clk),
            .rst_n        (rst_n),
            .vs1_index    (vs1_index[s]),
            .vs1_valid    (vs1_valid[s]),
            .vs2_index    (vs2_index[s]),
            .vs2_valid    (vs2_valid[s]),
            .vd_index     (vd_index[s]),
            .vs3_valid    (vs3_valid[s]),
            .src_vrf_data (src_vrf_data[s]),
            .rob_valid    (rob_valid),
            .rob_done     (rob_done),
            .rob_xrf      (rob_xrf),
            .rob_w_index  (rob_w_index),
            .rob_w_data   (rob_w_data),
            .rob_head     (rob_head),
            .raw_rob      (raw_rob[s]),
            .vs1_data     (rs_vs1_data[s]),
            .vs2_data     (rs_vs2_data[s]),
            .vs3_data     (rs_vs3_data[s])
        );
    end

    dispatch_ctrl #(.ROB_DEPTH(ROB_DEPTH)) u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .uop_valid    (uop_valid),
        .uop_exe      (uop_exe),
        .vd_index     (vd_index),
        .vd_valid     (vd_valid),
        .vs1_index    (vs1_index),
        .vs1_valid    (vs1_valid),
        .vs2_index    (vs2_index),
        .vs2_valid    (vs2_valid),
        .vs3_valid    (vs3_valid),
        .raw_rob      (raw_rob),
        .strct_hazard (strct_hazard),
        .rob_tail     (rob_tail),
        .alu_ready    (alu_ready),
        .mul_ready    (mul_ready),
        .rob_ready    (rob_ready),
        .uop_ready    (uop_ready),
        .rob_push     (rob_push),
        .rob_push_vd  (rob_push_vd),
        .alu_valid    (alu_valid),
        .mul_valid    (mul_valid),
        .rs_rob_addr  (rs_rob_addr)
    );

endmodule

`default_nettype wire

/* verif/tb_rvv_dispatch.sv */
/*
 Random testbench for the two-wide vector dispatch stage.
 Outputs are compared at the falling edge against a reference model.
 The VRF model assumes VLEN is a multiple of 32.
*/
`default_nettype none

module tb_rvv_dispatch;

    localparam int NS = rvv_uop_pkg::NUM_DP_UOP;
    localparam int RW = rvv_uop_pkg::REG_IDX_W;
    localparam int NSRC = rvv_uop_pkg::NUM_SRC;
    localparam int NRD = rvv_res_pkg::NUM_VRF_RD;
    localparam int ROB_DEPTH = rvv_res_pkg::DEF_ROB_DEPTH;
    localparam int VLEN = rvv_res_pkg::DEF_VLEN;
    localparam int AW = $clog2(ROB_DEPTH);
    localparam int RESET_CYCLES = 8;
    localparam int TEST_CYCLES = 2000;
    localparam int CYCLE_LIMIT = RESET_CYCLES + TEST_CYCLES + 92;

    // Starts low without a time-zero edge
    logic clk = 1'b0;
    logic rst_n;
    logic [NS-1:0] uop_valid, uop_exe, vs1_valid, vs2_valid, vd_valid, vs3_valid;
    logic [NS-1:0][RW-1:0] vs1_index, vs2_index, vd_index;
    logic [NS-1:0] uop_ready, rob_push, rob_ready;
    logic [ROB_DEPTH-1:0] rob_valid, rob_done, rob_xrf;
    logic [ROB_DEPTH-1:0][RW-1:0] rob_w_index;
    logic [ROB_DEPTH-1:0][VLEN-1:0] rob_w_data;
    logic [AW-1:0] rob_head, rob_tail;
    logic [NS-1:0][RW-1:0] rob_push_vd;
    logic [NS-1:0] alu_valid, alu_ready, mul_valid, mul_ready;
    logic [NS-1:0][AW-1:0] rs_rob_addr;
    logic [NS-1:0][VLEN-1:0] rs_vs1_data, rs_vs2_data, rs_vs3_data;
    logic [NRD-1:0][RW-1:0] vrf_rd_index;
    logic [NRD-1:0][VLEN-1:0] vrf_rd_data;

    // Expected values, filled by ref_dispatch
    logic [NS-1:0] exp_issue, exp_alu, exp_mul;
    logic [NS-1:0][AW-1:0] exp_addr;
    logic [NS-1:0][NSRC-1:0][VLEN-1:0] exp_data;
    logic [NS-1:0][NSRC-1:0] exp_chk, exp_fwd;
    logic [NRD-1:0][RW-1:0] exp_rd_index;
    logic exp_strct, exp_raw_uop;
    logic [NS-1:0] exp_raw;

    int cycle_count = 0;
    int n_dual = 0;
    int n_stall = 0;
    int n_strct = 0;
    int n_fwd = 0;
    int n_order = 0;

    rvv_dispatch #(.ROB_DEPTH(ROB_DEPTH), .VLEN(VLEN)) uut (
        .clk(clk), .rst_n(rst_n),
        .uop_valid(uop_valid), .uop_exe(uop_exe),
        .vs1_index(vs1_index), .vs1_valid(vs1_valid),
        .vs2_index(vs2_index), .vs2_valid(vs2_valid),
        .vd_index(vd_index), .vd_valid(vd_valid), .vs3_valid(vs3_valid),
        .uop_ready(uop_ready),
        .rob_valid(rob_valid), .rob_done(rob_done), .rob_xrf(rob_xrf),
        .rob_w_index(rob_w_index), .rob_w_data(rob_w_data),
        .rob_head(rob_head), .rob_tail(rob_tail),
        .rob_push(rob_push), .rob_push_vd(rob_push_vd), .rob_ready(rob_ready),
        .alu_valid(alu_valid), .alu_ready(alu_ready),
        .mul_valid(mul_valid), .mul_ready(mul_ready),
        .rs_rob_addr(rs_rob_addr),
        .rs_vs1_data(rs_vs1_data), .rs_vs2_data(rs_vs2_data), .rs_vs3_data(rs_vs3_data),
        .vrf_rd_index(vrf_rd_index), .vrf_rd_data(vrf_rd_data)
    );

    always #4 clk = ~clk;

    // VRF content is a fixed function of the register index
    function automatic logic [VLEN-1:0] vrf_pattern(input logic [RW-1:0] idx);
        logic [31:0] w;
        logic [VLEN-1:0] r;
        w = {8'hA5, 3'b000, idx, 8'h3C, 3'b000, idx};
        for (int i = 0; i < VLEN / 32; i++) begin
            r[i*32 +: 32] = w ^ {4{8'(i)}};
        end
        return r;
    endfunction

    always_comb begin
        for (int p = 0; p < NRD; p++) begin
            vrf_rd_data[p] = vrf_pattern(vrf_rd_index[p]);
        end
    end

    function automatic logic chance(input int pct);
        return int'($urandom % 100) < pct;
    endfunction

    function automatic void ref_dispatch();
        logic [NS-1:0][NSRC-1:0][RW-1:0] idx;
        logic [NS-1:0][NSRC-1:0] val;
        logic [NS-1:0] rs_rdy;
        int total;
        int p;
        int ent;
        idx = '0;
        val = '0;
        total = 0;
        p = 0;
        exp_rd_index = '0;
        exp_data = '0;
        exp_chk = '0;
        exp_fwd = '0;
        exp_raw = '0;
        for (int s = 0; s < NS; s++) begin
            idx[s] = {vd_index[s], vs2_index[s], vs1_index[s]};
            val[s] = {vs3_valid[s], vs2_valid[s], vs1_valid[s]};
            for (int k = 0; k < NSRC; k++) begin
                total += int'(val[s][k]);
            end
        end
        exp_strct = total > NRD;
        for (int s = 0; s < NS; s++) begin
            for (int k = 0; k < NSRC; k++) begin
                if (val[s][k]) begin
                    // Ports go to slot 0 first, slot 1 only without a port shortage
                    if (s == 0 || !exp_strct) begin
                        exp_rd_index[p] = idx[s][k];
                        exp_data[s][k] = vrf_pattern(idx[s][k]);
                        p++;
                    end
                    // Oldest to youngest, so the youngest match is kept
                    for (int j = 0; j < ROB_DEPTH; j++) begin
                        ent = (int'(rob_head) + j) % ROB_DEPTH;
                        if (rob_valid[ent] && !rob_xrf[ent] && rob_w_index[ent] == idx[s][k]) begin
                            exp_fwd[s][k] = 1'b1;
                            exp_data[s][k] = rob_w_data[ent];
                            if (!rob_done[ent]) exp_raw[s] = 1'b1;
                        end
                    end
                end
            end
        end
        for (int s = 0; s < NS; s++) begin
            rs_rdy[s] = (uop_exe[s] == rvv_uop_pkg::EXE_MUL) ? mul_ready[s] : alu_ready[s];
            for (int k = 0; k < NSRC; k++) begin
                exp_chk[s][k] = val[s][k] && !exp_raw[s] && (exp_fwd[s][k] || s == 0 || !exp_strct);
            end
            exp_addr[s] = AW'((int'(rob_tail) + s) % ROB_DEPTH);
        end
        exp_raw_uop = vd_valid[0] && ((val[1][0] && idx[1][0] == vd_index[0]) ||
                      (val[1][1] && idx[1][1] == vd_index[0]) ||
                      (val[1][2] && idx[1][2] == vd_index[0]));
        exp_issue[0] = uop_valid[0] && !exp_raw[0] && rs_rdy[0] && rob_ready[0];
        exp_issue[1] = exp_issue[0] && uop_valid[1] && !exp_raw[1] && !exp_raw_uop &&
                       !exp_strct && rs_rdy[1] && rob_ready[1];
        for (int s = 0; s < NS; s++) begin
            exp_mul[s] = exp_issue[s] && uop_exe[s] == rvv_uop_pkg::EXE_MUL;
            exp_alu[s] = exp_issue[s] && uop_exe[s] == rvv_uop_pkg::EXE_ALU;
        end
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1, "dispatch output mismatch");
    endtask

    task automatic check_ctrl(input logic [NS-1:0] got, input logic [NS-1:0] exp, input string what);
        if (got !== exp)
            stop_on_error($sformatf("ERR @%0t: %s got %b expected %b", $time, what, got, exp));
    endtask

    task automatic check_addr(input logic [AW-1:0] got, input logic [AW-1:0] exp, input string what);
        if (got !== exp)
            stop_on_error($sformatf("ERR @%0t: %s got %0d expected %0d", $time, what, got, exp));
    endtask

    task automatic check_data(input logic [VLEN-1:0] got, input logic [VLEN-1:0] exp,
                              input string what);
        if (got !== exp)
            stop_on_error($sformatf("ERR @%0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_index(input logic [RW-1:0] got, input logic [RW-1:0] exp, input string what);
        if (got !== exp)
            stop_on_error($sformatf("ERR @%0t: %s got %0d expected %0d", $time, what, got, exp));
    endtask

    // Inputs settle one unit after the rising edge, so the falling edge is safe
    always @(negedge clk) begin : compare
        logic [VLEN-1:0] got;
        ref_dispatch();
        check_ctrl(uop_ready, exp_issue, "uop_ready");
        check_ctrl(rob_push, exp_issue, "rob_push");
        check_ctrl(alu_valid, exp_alu, "alu_valid");
        check_ctrl(mul_valid, exp_mul, "mul_valid");
        for (int p = 0; p < NRD; p++) begin
            check_index(vrf_rd_index[p], exp_rd_index[p], $sformatf("vrf_rd_index[%0d]", p));
        end
        for (int s = 0; s < NS; s++) begin
            check_addr(rs_rob_addr[s], exp_addr[s], $sformatf("rs_rob_addr[%0d]", s));
            check_index(rob_push_vd[s], vd_index[s], $sformatf("rob_push_vd[%0d]", s));
            for (int k = 0; k < NSRC; k++) begin
                got = (k == 0) ? rs_vs1_data[s] : (k == 1) ? rs_vs2_data[s] : rs_vs3_data[s];
                if (exp_chk[s][k]) begin
                    check_data(got, exp_data[s][k], $sformatf("vs%0d data slot %0d", k + 1, s));
                    if (exp_fwd[s][k]) n_fwd++;
                end
            end
        end
        if (exp_issue[1]) n_dual++;
        if (uop_valid[0] && exp_raw[0]) n_stall++;
        if (exp_strct && uop_valid[1]) n_strct++;
        if (exp_issue[0] && uop_valid[1] && exp_raw_uop) n_order++;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run passed %0d cycles without finishing", CYCLE_LIMIT);
            $display("TB FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic clear_inputs();
        {uop_valid, uop_exe, vs1_valid, vs2_valid, vd_valid, vs3_valid} = '0;
        {vs1_index, vs2_index, vd_index} = '0;
        {rob_valid, rob_done, rob_xrf, rob_w_index, rob_w_data} = '0;
        {rob_head, rob_tail} = '0;
        {rob_ready, alu_ready, mul_ready} = '0;
    endtask

    task automatic drive_random();
        for (int s = 0; s < NS; s++) begin
            uop_valid[s] = chance(85);
            uop_exe[s] = chance(40);
            vs1_index[s] = RW'($urandom % 16);
            vs2_index[s] = RW'($urandom % 16);
            vd_index[s] = RW'($urandom % 16);
            vs1_valid[s] = chance(70);
            vs2_valid[s] = chance(70);
            vd_valid[s] = chance(70);
            vs3_valid[s] = chance(30);
            rob_ready[s] = chance(85);
            alu_ready[s] = chance(85);
            mul_ready[s] = chance(85);
        end
        // Make slot 1 read slot 0's destination now and then
        if (chance(25)) begin
            vs1_index[1] = vd_index[0];
            vs1_valid[1] = 1'b1;
            vd_valid[0] = 1'b1;
        end
        for (int k = 0; k < ROB_DEPTH; k++) begin
            rob_valid[k] = chance(75);
            rob_done[k] = chance(70);
            rob_xrf[k] = chance(15);
            rob_w_index[k] = chance(80) ? RW'($urandom % 8) : RW'($urandom % 32);
            rob_w_data[k] = {$urandom, $urandom, $urandom, $urandom};
        end
        if (chance(15)) rob_valid = '0;
        rob_head = AW'($urandom % ROB_DEPTH);
        rob_tail = AW'($urandom % ROB_DEPTH);
    endtask

    initial begin
        void'($urandom(22));
        rst_n = 1'b0;
        clear_inputs();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        drive_random();
        for (int i = 1; i < TEST_CYCLES; i++) begin
            @(posedge clk);
            #1;
            drive_random();
        end
        @(negedge clk);
        @(posedge clk);
        if (n_dual == 0 || n_stall == 0 || n_strct == 0 || n_fwd == 0 || n_order == 0) begin
            $display("Stimulus missed a case: dual %0d stall %0d strct %0d fwd %0d order %0d",
                     n_dual, n_stall, n_strct, n_fwd, n_order);
            $display("TB FAILED");
            $fatal(1, "coverage hole");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* rvv_dispatch.f */
src/rvv_uop_pkg.sv
src/rvv_res_pkg.sv
src/dispatch_vrf_read.sv
src/dispatch_rob_forward.sv
src/dispatch_ctrl.sv
src/rvv_dispatch.sv
verif/tb_rvv_dispatch.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the dispatch testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_rvv_dispatch \
    -f rvv_dispatch.f \
    --Mdir obj_dir -o sim_rvv_dispatch

./obj_dir/sim_rvv_dispatch
